// ==== src/isaPkg.sv ====
package isaPkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction word views
    //////////////////////////////////////////////////////////////////////

    // Two-address register format, rs <= rs op rt
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] shamt;
        logic [5:0] unused;
        logic [4:0] func;
    } rFormat;

    // Immediate, load/store and conditional branch format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat;

    // Jump and call format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] label;
    } jFormat;

    typedef union packed {
        rFormat rType;
        iFormat iType;
        jFormat jType;
    } instrWord;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_RTYPE = 6'h00;
    // rs <= rs op imm, addi sign-extends, logic ops zero-extend
    localparam logic [5:0] OP_ADDI  = 6'h01;
    localparam logic [5:0] OP_ANDI  = 6'h02;
    localparam logic [5:0] OP_ORI   = 6'h03;
    localparam logic [5:0] OP_XORI  = 6'h04;
    // lw rt <= mem[rs + imm], sw mem[rs + imm] <= rt
    localparam logic [5:0] OP_LW    = 6'h05;
    localparam logic [5:0] OP_SW    = 6'h06;
    // Branches test the flags of rs + rt, target nextPC + imm * 4
    localparam logic [5:0] OP_BZ    = 6'h07;
    localparam logic [5:0] OP_BNZ   = 6'h08;
    localparam logic [5:0] OP_BNEG  = 6'h09;
    localparam logic [5:0] OP_BCY   = 6'h0A;
    localparam logic [5:0] OP_J     = 6'h0B;
    localparam logic [5:0] OP_JAL   = 6'h0C;
    // Jump to the address held in rs
    localparam logic [5:0] OP_JR    = 6'h0D;

    // R-type function codes
    localparam logic [4:0] FN_ADD = 5'd0;
    localparam logic [4:0] FN_SUB = 5'd1;
    localparam logic [4:0] FN_AND = 5'd2;
    localparam logic [4:0] FN_OR  = 5'd3;
    localparam logic [4:0] FN_XOR = 5'd4;
    localparam logic [4:0] FN_NOR = 5'd5;
    localparam logic [4:0] FN_SLL = 5'd6;
    localparam logic [4:0] FN_SRL = 5'd7;
    localparam logic [4:0] FN_SRA = 5'd8;
    localparam logic [4:0] FN_SLT = 5'd9;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT
    } aluOp;

    localparam logic [4:0] LINK_REG = 5'd31;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

endpackage

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

    // Register written back
    typedef enum logic [1:0] {
        DST_RS,
        DST_RT,
        DST_LINK
    } regDstSel;

    // Writeback source, order follows the writeback mux inputs
    typedef enum logic [1:0] {
        WB_LINK,
        WB_MEM,
        WB_ALU
    } wbSel;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_ZERO,
        BR_NZERO,
        BR_NEG,
        BR_CARRY
    } branchCond;

    typedef enum logic [1:0] {
        NX_SEQ,
        NX_LABEL,
        NX_REG
    } nextSel;

    typedef struct packed {
        regDstSel      regDst;
        logic          regWrite;
        logic          memRead;
        logic          memWrite;
        wbSel          wbSel;
        logic          aluSrcImm;
        isaPkg::aluOp  aluOp;
        logic          signExtend;
        branchCond     branchCond;
        nextSel        nextSel;
    } ctrlWord;

    typedef struct packed {
        logic carry;
        logic zero;
        logic sign;
    } aluFlags;

endpackage

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  isaPkg::instrWord instr,
    output ctrlPkg::ctrlWord ctrl
);

    always_comb begin
        // No-op defaults, sequential flow with nothing written
        ctrl.regDst     = ctrlPkg::DST_RS;
        ctrl.regWrite   = 1'b0;
        ctrl.memRead    = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.wbSel      = ctrlPkg::WB_ALU;
        ctrl.aluSrcImm  = 1'b0;
        ctrl.aluOp      = isaPkg::ALU_ADD;
        ctrl.signExtend = 1'b1;
        ctrl.branchCond = ctrlPkg::BR_NONE;
        ctrl.nextSel    = ctrlPkg::NX_SEQ;

        case (instr.rType.opcode)
            isaPkg::OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (instr.rType.func)
                    isaPkg::FN_ADD: ctrl.aluOp = isaPkg::ALU_ADD;
                    isaPkg::FN_SUB: ctrl.aluOp = isaPkg::ALU_SUB;
                    isaPkg::FN_AND: ctrl.aluOp = isaPkg::ALU_AND;
                    isaPkg::FN_OR:  ctrl.aluOp = isaPkg::ALU_OR;
                    isaPkg::FN_XOR: ctrl.aluOp = isaPkg::ALU_XOR;
                    isaPkg::FN_NOR: ctrl.aluOp = isaPkg::ALU_NOR;
                    isaPkg::FN_SLL: ctrl.aluOp = isaPkg::ALU_SLL;
                    isaPkg::FN_SRL: ctrl.aluOp = isaPkg::ALU_SRL;
                    isaPkg::FN_SRA: ctrl.aluOp = isaPkg::ALU_SRA;
                    isaPkg::FN_SLT: ctrl.aluOp = isaPkg::ALU_SLT;
                    // Unknown function acts as a no-op
                    default:        ctrl.regWrite = 1'b0;
                endcase
            end
            isaPkg::OP_ADDI, isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.signExtend = (instr.iType.opcode == isaPkg::OP_ADDI);
                case (instr.iType.opcode)
                    isaPkg::OP_ANDI: ctrl.aluOp = isaPkg::ALU_AND;
                    isaPkg::OP_ORI:  ctrl.aluOp = isaPkg::ALU_OR;
                    isaPkg::OP_XORI: ctrl.aluOp = isaPkg::ALU_XOR;
                    default:         ctrl.aluOp = isaPkg::ALU_ADD;
                endcase
            end
            isaPkg::OP_LW: begin
                ctrl.regDst    = ctrlPkg::DST_RT;
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.wbSel     = ctrlPkg::WB_MEM;
                ctrl.aluSrcImm = 1'b1;
            end
            isaPkg::OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            isaPkg::OP_BZ:   ctrl.branchCond = ctrlPkg::BR_ZERO;
            isaPkg::OP_BNZ:  ctrl.branchCond = ctrlPkg::BR_NZERO;
            isaPkg::OP_BNEG: ctrl.branchCond = ctrlPkg::BR_NEG;
            isaPkg::OP_BCY:  ctrl.branchCond = ctrlPkg::BR_CARRY;
            isaPkg::OP_J:    ctrl.nextSel    = ctrlPkg::NX_LABEL;
            isaPkg::OP_JAL: begin
                ctrl.regDst   = ctrlPkg::DST_LINK;
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = ctrlPkg::WB_LINK;
                ctrl.nextSel  = ctrlPkg::NX_LABEL;
            end
            isaPkg::OP_JR:   ctrl.nextSel    = ctrlPkg::NX_REG;
            default: ;
        endcase
    end

    // A single memory port, never read and written together
    always_comb begin
        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("controlUnit: memRead and memWrite both set");
    end

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic        regWrite,
    input  logic [4:0]  writeReg,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: 32'd0};
        end else if (regWrite && writeReg != 5'd0) begin
            regs[writeReg] <= writeData;
        end
    end

    // Register 0 always reads as zero
    assign readData1 = (rs == 5'd0) ? 32'd0 : regs[rs];
    assign readData2 = (rt == 5'd0) ? 32'd0 : regs[rt];

    // Datapath holds regWrite low while reset is high
    property noWriteInReset;
        @(posedge clk) reset |-> !regWrite;
    endproperty

    assert property (noWriteInReset)
        else $error("registerFile: write requested during reset");

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  logic [4:0]       shamt,
    input  isaPkg::aluOp     op,
    output logic [31:0]      result,
    output ctrlPkg::aluFlags flags
);

    logic [32:0] sumWide;
    logic [32:0] diffWide;
    logic        carryOut;

    // Extra top bit holds the carry-out or the borrow
    assign sumWide  = {1'b0, a} + {1'b0, b};
    assign diffWide = {1'b0, a} - {1'b0, b};

    always_comb begin
        carryOut = 1'b0;
        case (op)
            isaPkg::ALU_ADD: begin
                result   = sumWide[31:0];
                carryOut = sumWide[32];
            end
            isaPkg::ALU_SUB: begin
                result   = diffWide[31:0];
                carryOut = diffWide[32];
            end
            isaPkg::ALU_AND: result = a & b;
            isaPkg::ALU_OR:  result = a | b;
            isaPkg::ALU_XOR: result = a ^ b;
            isaPkg::ALU_NOR: result = ~(a | b);
            isaPkg::ALU_SLL: result = a << shamt;
            isaPkg::ALU_SRL: result = a >> shamt;
            isaPkg::ALU_SRA: result = $unsigned($signed(a) >>> shamt);
            isaPkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            default:         result = 32'd0;
        endcase
    end

    assign flags.carry = carryOut;
    assign flags.zero  = (result == 32'd0);
    assign flags.sign  = result[31];

endmodule

// ==== src/branchUnit.sv ====
`timescale 1ns/1ps

module branchUnit (
    input  logic [31:0]        instrAddr,
    input  logic [25:0]        label,
    input  logic [15:0]        imm,
    input  logic [31:0]        rsValue,
    input  ctrlPkg::aluFlags   flags,
    input  ctrlPkg::branchCond cond,
    input  ctrlPkg::nextSel    sel,
    output logic [31:0]        nextPC,
    output logic [31:0]        nextInstrAddr
);

    logic        taken;
    logic [31:0] branchTarget;
    logic [31:0] labelTarget;

    assign nextPC = instrAddr + 32'd4;

    // Word offset from the following instruction
    assign branchTarget = nextPC + {{14{imm[15]}}, imm, 2'b00};

    // Stays inside the current 256 MB region
    assign labelTarget = {nextPC[31:28], label, 2'b00};

    always_comb begin
        case (cond)
            ctrlPkg::BR_ZERO:  taken = flags.zero;
            ctrlPkg::BR_NZERO: taken = !flags.zero;
            ctrlPkg::BR_NEG:   taken = flags.sign;
            ctrlPkg::BR_CARRY: taken = flags.carry;
            default:           taken = 1'b0;
        endcase
    end

    always_comb begin
        case (sel)
            ctrlPkg::NX_LABEL: nextInstrAddr = labelTarget;
            ctrlPkg::NX_REG:   nextInstrAddr = rsValue;
            default:           nextInstrAddr = taken ? branchTarget : nextPC;
        endcase
    end

    // Relies on the PC itself staying aligned
    always_comb begin
        if (sel != ctrlPkg::NX_REG) begin
            assert (nextInstrAddr[1:0] == 2'b00)
                else $error("branchUnit: misaligned next address %h", nextInstrAddr);
        end
    end

endmodule

// ==== src/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  wordAddr,
    input  logic        writeEnable,
    input  logic [31:0] writeData,
    output logic [31:0] readData
);

    logic [31:0] mem [isaPkg::DMEM_WORDS];

    // Contents survive reset, only the write is held off
    always_ff @(posedge clk) begin
        if (writeEnable && !reset) begin
            mem[wordAddr] <= writeData;
        end
    end

    // Same-cycle load data
    assign readData = mem[wordAddr];

endmodule

// ==== src/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic             clk,
    input  logic             reset,
    input  ctrlPkg::ctrlWord ctrl,
    output isaPkg::instrWord instruction,
    output logic [31:0]      instrAddr,
    output logic [31:0]      result,
    output logic             wbEnable,
    output logic [4:0]       wbReg,
    output logic [31:0]      wbData
);

    logic [31:0] imem [isaPkg::IMEM_WORDS];

    logic [4:0]       rs;
    logic [4:0]       rt;
    logic [15:0]      imm;
    logic [31:0]      readData1;
    logic [31:0]      readData2;
    logic [31:0]      extImm;
    logic [31:0]      operandB;
    logic [31:0]      memData;
    logic [31:0]      nextPC;
    logic [31:0]      nextInstrAddr;
    logic             memWriteEn;
    ctrlPkg::aluFlags flags;

    //////////////////////////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            instrAddr <= 32'd0;
        end else begin
            instrAddr <= nextInstrAddr;
        end
    end

    initial begin
        $readmemh("program.hex", imem);
    end

    assign instruction = imem[instrAddr[9:2]];

    // rs and rt sit at the same place in R and I formats
    assign rs  = instruction.iType.rs;
    assign rt  = instruction.iType.rt;
    assign imm = instruction.iType.imm;

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.regDst)
            ctrlPkg::DST_RT:   wbReg = rt;
            ctrlPkg::DST_LINK: wbReg = isaPkg::LINK_REG;
            default:           wbReg = rs;
        endcase
    end

    // No state changes while reset is held
    assign wbEnable   = ctrl.regWrite & ~reset;
    assign memWriteEn = ctrl.memWrite & ~reset;

    registerFile regFile (
        .clk      (clk),
        .reset    (reset),
        .rs       (rs),
        .rt       (rt),
        .regWrite (wbEnable),
        .writeReg (wbReg),
        .writeData(wbData),
        .readData1(readData1),
        .readData2(readData2)
    );

    assign extImm   = ctrl.signExtend ? {{16{imm[15]}}, imm} : {16'd0, imm};
    assign operandB = ctrl.aluSrcImm ? extImm : readData2;

    alu alu1 (
        .a     (readData1),
        .b     (operandB),
        .shamt (instruction.rType.shamt),
        .op    (ctrl.aluOp),
        .result(result),
        .flags (flags)
    );

    branchUnit branch1 (
        .instrAddr    (instrAddr),
        .label        (instruction.jType.label),
        .imm          (imm),
        .rsValue      (readData1),
        .flags        (flags),
        .cond         (ctrl.branchCond),
        .sel          (ctrl.nextSel),
        .nextPC       (nextPC),
        .nextInstrAddr(nextInstrAddr)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory and writeback
    //////////////////////////////////////////////////////////////////////

    dataMemory dataMem (
        .clk        (clk),
        .reset      (reset),
        .wordAddr   (result[9:2]),
        .writeEnable(memWriteEn),
        .writeData  (readData2),
        .readData   (memData)
    );

    always_comb begin
        case (ctrl.wbSel)
            ctrlPkg::WB_LINK: wbData = nextPC;
            ctrlPkg::WB_MEM:  wbData = memData;
            default:          wbData = result;
        endcase
    end

    // Base plus offset must land on a word
    assert property (@(posedge clk) disable iff (reset)
        (ctrl.memRead || ctrl.memWrite) |-> (result[1:0] == 2'b00))
        else $error("datapath: misaligned memory address %h", result);

endmodule

// ==== src/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
    input  logic             clk,
    input  logic             reset,
    output isaPkg::instrWord instruction,
    output logic [31:0]      instrAddr,
    output logic [31:0]      result,
    output logic             wbEnable,
    output logic [4:0]       wbReg,
    output logic [31:0]      wbData
);

    ctrlPkg::ctrlWord ctrl;

    // Decode feeds straight back into the same cycle
    controlUnit control (
        .instr(instruction),
        .ctrl (ctrl)
    );

    datapath dp (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .instruction(instruction),
        .instrAddr  (instrAddr),
        .result     (result),
        .wbEnable   (wbEnable),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

endmodule

// ==== sim/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_ROWS     = 32;
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_ROWS + 50;

    // Writeback port as seen on the core outputs
    typedef struct packed {
        logic        enable;
        logic [4:0]  regNum;
        logic [31:0] data;
    } wbPort;

    // One retired instruction
    typedef struct packed {
        logic [31:0]      addr;
        isaPkg::instrWord instr;
        logic [31:0]      result;
        wbPort            wb;
    } traceRow;

    logic             clk;
    logic             reset;
    isaPkg::instrWord instruction;
    logic [31:0]      instrAddr;
    logic [31:0]      result;
    logic             wbEnable;
    logic [4:0]       wbReg;
    logic [31:0]      wbData;

    string   rowName [NUM_ROWS];
    traceRow expected [NUM_ROWS];
    int      rowCount;
    int      passCount;
    int      failCount;
    int      errorCount;
    int      cycleCount;

    cpuCore UUT (
        .clk        (clk),
        .reset      (reset),
        .instruction(instruction),
        .instrAddr  (instrAddr),
        .result     (result),
        .wbEnable   (wbEnable),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkAddr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: instrAddr expected %h, actual %h", name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkInstr(input string name, input isaPkg::instrWord exp,
                              input isaPkg::instrWord act);
        if (act !== exp) begin
            $display("[FAIL] %s: instruction expected %h, actual %h", name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: result expected %h, actual %h", name, exp, act);
            errorCount++;
        end
    endtask

    // Register and data only matter when a write is expected
    task automatic checkWrite(input string name, input wbPort exp, input wbPort act);
        if (act.enable !== exp.enable) begin
            $display("[FAIL] %s: wbEnable expected %b, actual %b", name, exp.enable, act.enable);
            errorCount++;
        end else if (exp.enable && (act.regNum !== exp.regNum || act.data !== exp.data)) begin
            $display("[FAIL] %s: writeback expected r%0d = %h, actual r%0d = %h",
                     name, exp.regNum, exp.data, act.regNum, act.data);
            errorCount++;
        end
    endtask

    function automatic wbPort currentWb();
        return {wbEnable, wbReg, wbData};
    endfunction

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("[PASS] %s", name);
        end else begin
            failCount++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Expected trace worked out by hand from the ISA rules
    //////////////////////////////////////////////////////////////////////

    task automatic addRow(input string name, input logic [31:0] addr,
                          input isaPkg::instrWord instr, input logic [31:0] res,
                          input logic en, input logic [4:0] regNum, input logic [31:0] data);
        rowName[rowCount]            = name;
        expected[rowCount].addr      = addr;
        expected[rowCount].instr     = instr;
        expected[rowCount].result    = res;
        expected[rowCount].wb.enable = en;
        expected[rowCount].wb.regNum = regNum;
        expected[rowCount].wb.data   = data;
        rowCount++;
    endtask

    task automatic loadTrace();
        addRow("addiR1",       32'h0000_0000, 32'h0420_0005,
               32'h0000_0005, 1'b1, 5'd1,  32'h0000_0005);
        addRow("addiNegR2",    32'h0000_0004, 32'h0440_FFFD,
               32'hFFFF_FFFD, 1'b1, 5'd2,  32'hFFFF_FFFD);
        addRow("addR1R2",      32'h0000_0008, 32'h0022_0000,
               32'h0000_0002, 1'b1, 5'd1,  32'h0000_0002);
        addRow("subR2R1",      32'h0000_000C, 32'h0041_0001,
               32'hFFFF_FFFB, 1'b1, 5'd2,  32'hFFFF_FFFB);
        addRow("oriR3",        32'h0000_0010, 32'h0C60_00F0,
               32'h0000_00F0, 1'b1, 5'd3,  32'h0000_00F0);
        addRow("xoriR3",       32'h0000_0014, 32'h1060_0FF0,
               32'h0000_0F00, 1'b1, 5'd3,  32'h0000_0F00);
        // Zero-extended immediate clears the upper half
        addRow("andiZeroExt",  32'h0000_0018, 32'h0840_8F0F,
               32'h0000_8F0B, 1'b1, 5'd2,  32'h0000_8F0B);
        addRow("andR2R3",      32'h0000_001C, 32'h0043_0002,
               32'h0000_0F00, 1'b1, 5'd2,  32'h0000_0F00);
        addRow("orR2R1",       32'h0000_0020, 32'h0041_0003,
               32'h0000_0F02, 1'b1, 5'd2,  32'h0000_0F02);
        addRow("xorR2R3",      32'h0000_0024, 32'h0043_0004,
               32'h0000_0002, 1'b1, 5'd2,  32'h0000_0002);
        addRow("norR2R3",      32'h0000_0028, 32'h0043_0005,
               32'hFFFF_F0FD, 1'b1, 5'd2,  32'hFFFF_F0FD);
        addRow("sllR3",        32'h0000_002C, 32'h0060_2006,
               32'h0000_F000, 1'b1, 5'd3,  32'h0000_F000);
        addRow("sraR2",        32'h0000_0030, 32'h0040_4008,
               32'hFFFF_FFF0, 1'b1, 5'd2,  32'hFFFF_FFF0);
        addRow("srlR2",        32'h0000_0034, 32'h0040_E007,
               32'h0000_000F, 1'b1, 5'd2,  32'h0000_000F);
        addRow("sltR1R3",      32'h0000_0038, 32'h0023_0009,
               32'h0000_0001, 1'b1, 5'd1,  32'h0000_0001);
        addRow("addiR0",       32'h0000_003C, 32'h0400_0007,
               32'h0000_0007, 1'b1, 5'd0,  32'h0000_0007);
        // Base r0 must still read zero here
        addRow("swR3",         32'h0000_0040, 32'h1803_0010,
               32'h0000_0010, 1'b0, 5'd0,  32'h0000_0000);
        addRow("lwR4",         32'h0000_0044, 32'h1424_000F,
               32'h0000_0010, 1'b1, 5'd4,  32'h0000_F000);
        addRow("bzTaken",      32'h0000_0048, 32'h1C00_0001,
               32'h0000_0000, 1'b0, 5'd0,  32'h0000_0000);
        addRow("bzNotTaken",   32'h0000_0050, 32'h1C20_0005,
               32'h0000_0001, 1'b0, 5'd0,  32'h0000_0000);
        addRow("bnzTaken",     32'h0000_0054, 32'h2080_0001,
               32'h0000_F000, 1'b0, 5'd0,  32'h0000_0000);
        addRow("bnegNotTaken", 32'h0000_005C, 32'h2440_0003,
               32'h0000_000F, 1'b0, 5'd0,  32'h0000_0000);
        addRow("addiR6",       32'h0000_0060, 32'h04C0_FFFF,
               32'hFFFF_FFFF, 1'b1, 5'd6,  32'hFFFF_FFFF);
        addRow("bnegTaken",    32'h0000_0064, 32'h24C0_0001,
               32'hFFFF_FFFF, 1'b0, 5'd0,  32'h0000_0000);
        addRow("bcyTaken",     32'h0000_006C, 32'h28C1_0001,
               32'h0000_0000, 1'b0, 5'd0,  32'h0000_0000);
        addRow("bcyNotTaken",  32'h0000_0074, 32'h2841_0001,
               32'h0000_0010, 1'b0, 5'd0,  32'h0000_0000);
        addRow("jalCall",      32'h0000_0078, 32'h3000_0021,
               32'h0000_0000, 1'b1, 5'd31, 32'h0000_007C);
        // r5 still zero proves every skipped write stayed skipped
        addRow("addiR5",       32'h0000_0084, 32'h04A0_0077,
               32'h0000_0077, 1'b1, 5'd5,  32'h0000_0077);
        addRow("jrReturn",     32'h0000_0088, 32'h37E0_0000,
               32'h0000_007C, 1'b0, 5'd0,  32'h0000_0000);
        addRow("addiR7",       32'h0000_007C, 32'h04E0_1234,
               32'h0000_1234, 1'b1, 5'd7,  32'h0000_1234);
        addRow("jSelf",        32'h0000_0080, 32'h2C00_0020,
               32'h0000_0000, 1'b0, 5'd0,  32'h0000_0000);
        addRow("jSelfAgain",   32'h0000_0080, 32'h2C00_0020,
               32'h0000_0000, 1'b0, 5'd0,  32'h0000_0000);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int errorsBefore;
        int row;

        reset      <= 1'b1;
        rowCount   = 0;
        passCount  = 0;
        failCount  = 0;
        errorCount = 0;
        loadTrace();

        // PC parked at 0 and no writeback while reset is held
        errorsBefore = errorCount;
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            checkAddr("resetHold", 32'h0000_0000, instrAddr);
            checkWrite("resetHold", '0, currentWb());
        end
        @(posedge clk);
        reset <= 1'b0;
        finishTest("resetHold", errorsBefore);

        // One row per retired instruction sampled mid-cycle
        for (row = 0; row < rowCount; row++) begin
            @(negedge clk);
            errorsBefore = errorCount;
            checkAddr(rowName[row], expected[row].addr, instrAddr);
            checkInstr(rowName[row], expected[row].instr, instruction);
            checkWord(rowName[row], expected[row].result, result);
            checkWrite(rowName[row], expected[row].wb, currentWb());
            finishTest(rowName[row], errorsBefore);
            @(posedge clk);
        end

        $display("Summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Simulation timed out after %0d cycles", cycleCount);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== program.hex ====
// One 32-bit instruction word per line, loaded from word address 0
// Trailing comments give the byte address and the instruction
04200005 // 00 addi r1, 5
0440FFFD // 04 addi r2, -3
00220000 // 08 add  r1, r2
00410001 // 0C sub  r2, r1
0C6000F0 // 10 ori  r3, 0x00F0
10600FF0 // 14 xori r3, 0x0FF0
08408F0F // 18 andi r2, 0x8F0F
00430002 // 1C and  r2, r3
00410003 // 20 or   r2, r1
00430004 // 24 xor  r2, r3
00430005 // 28 nor  r2, r3
00602006 // 2C sll  r3, 4
00404008 // 30 sra  r2, 8
0040E007 // 34 srl  r2, 28
00230009 // 38 slt  r1, r3
04000007 // 3C addi r0, 7
18030010 // 40 sw   r3, 0x10(r0)
1424000F // 44 lw   r4, 0x0F(r1)
1C000001 // 48 bz   r0, r0, +1
04A00055 // 4C addi r5, 0x55 (skipped)
1C200005 // 50 bz   r1, r0, +5
20800001 // 54 bnz  r4, r0, +1
04A00055 // 58 addi r5, 0x55 (skipped)
24400003 // 5C bneg r2, r0, +3
04C0FFFF // 60 addi r6, -1
24C00001 // 64 bneg r6, r0, +1
04A00055 // 68 addi r5, 0x55 (skipped)
28C10001 // 6C bcy  r6, r1, +1
04A00055 // 70 addi r5, 0x55 (skipped)
28410001 // 74 bcy  r2, r1, +1
30000021 // 78 jal  0x84
04E01234 // 7C addi r7, 0x1234
2C000020 // 80 j    0x80
04A00077 // 84 addi r5, 0x77
37E00000 // 88 jr   r31

// ==== cpuCore.f ====
src/isaPkg.sv
src/ctrlPkg.sv
src/controlUnit.sv
src/registerFile.sv
src/alu.sv
src/branchUnit.sv
src/dataMemory.sv
src/datapath.sv
src/cpuCore.sv
sim/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpuCoreTb -Mdir obj_dir -o cpuCoreSim -f cpuCore.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuCoreSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1
